/* src/cache_tag_pkg.sv */
/* Sizes and types shared by the cache tag blocks. The pseudo-LRU tree is
   fixed at 4 ways, so NUM_WAYS and LRU_BITS are not free parameters. */
package cache_tag_pkg;

	localparam int NUM_SETS = 16;
	localparam int SET_INDEX_WIDTH = 4;
	localparam int TAG_WIDTH = 8;
	// The address is the tag placed above the set index
	localparam int ADDR_WIDTH = TAG_WIDTH + SET_INDEX_WIDTH;
	localparam int NUM_WAYS = 4;
	localparam int WAY_WIDTH = 2;
	localparam int LRU_BITS = 3;

	typedef logic [WAY_WIDTH-1:0] way_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} lookup_req_t;

	typedef enum logic [1:0] {
		RESULT_HIT,
		RESULT_FILL,
		RESULT_EVICT
	} lookup_result_e;

	// Victim tag is zero unless the result is an eviction
	typedef struct packed {
		lookup_result_e result;
		way_t way;
		logic [TAG_WIDTH-1:0] victim_tag;
	} lookup_resp_t;

	// Valid bits and tags of all ways in one set
	typedef struct packed {
		logic [NUM_WAYS-1:0] valid;
		logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag;
	} tag_set_t;

	// Set index field of a lookup address
	function automatic logic [SET_INDEX_WIDTH-1:0] req_set(lookup_req_t req);
		return req.addr[SET_INDEX_WIDTH-1:0];
	endfunction

	// Tag field of a lookup address
	function automatic logic [TAG_WIDTH-1:0] req_tag(lookup_req_t req);
		return req.addr[ADDR_WIDTH-1:SET_INDEX_WIDTH];
	endfunction

endpackage

/* src/sram_1r1w.sv */
/* Register-array memory, one registered read and one write per cycle.
   A write to the address being read returns the new data on the read. */
module sram_1r1w #(
	parameter int DATA_WIDTH = 8,
	parameter int SIZE = 16
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [$clog2(SIZE)-1:0] rd_addr_i,
	output logic [DATA_WIDTH-1:0]   rd_data_o,
	input  logic                    wr_en_i,
	input  logic [$clog2(SIZE)-1:0] wr_addr_i,
	input  logic [DATA_WIDTH-1:0]   wr_data_i
);

	logic [DATA_WIDTH-1:0] mem [SIZE];

	// Storage array, cleared to zero on reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < SIZE; i++)
				mem[i] <= '0;
		end
		else if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// The read happens every cycle
	// A write to the same entry bypasses the array so the reader sees fresh data
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rd_data_o <= '0;
		else if (wr_en_i && wr_addr_i == rd_addr_i)
			rd_data_o <= wr_data_i;
		else
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

/* src/cache_lru.sv */
/* Tree pseudo-LRU per set, 4 ways only. lru_way_o appears one cycle after
   set_i; an MRU update applies to the set presented in the previous cycle. */
module cache_lru
	import cache_tag_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [SET_INDEX_WIDTH-1:0] set_i,
	input  logic                       update_mru_i,
	input  way_t                       new_mru_way_i,
	output way_t                       lru_way_o
);

	// Tree bit layout
	// bit 1 is the root, 0 points to ways 0/1, 1 points to ways 2/3
	// bit 2 picks inside the left pair, 0 is way 0 and 1 is way 1
	// bit 0 picks inside the right pair, 0 is way 2 and 1 is way 3
	logic [LRU_BITS-1:0]        old_bits;
	logic [LRU_BITS-1:0]        new_bits;
	logic [SET_INDEX_WIDTH-1:0] set_q;

	sram_1r1w #(
		.DATA_WIDTH(LRU_BITS),
		.SIZE(NUM_SETS)
	) lru_mem_inst (
		.clk(clk),
		.reset(reset),
		.rd_addr_i(set_i),
		.rd_data_o(old_bits),
		.wr_en_i(update_mru_i),
		.wr_addr_i(set_q),
		.wr_data_i(new_bits)
	);

	// Remember which set the read data belongs to, the update goes back there
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			set_q <= '0;
		else
			set_q <= set_i;
	end

	// Follow the tree bits down to the least recently used way
	always_comb
	begin
		if (!old_bits[1])
			lru_way_o = old_bits[2] ? way_t'(1) : way_t'(0);
		else
			lru_way_o = old_bits[0] ? way_t'(3) : way_t'(2);
	end

	// Point every bit on the path of the new MRU way away from it
	// The bit of the other subtree keeps its old value
	always_comb
	begin
		case (new_mru_way_i)
			2'd0: new_bits = {2'b11, old_bits[0]};
			2'd1: new_bits = {2'b01, old_bits[0]};
			2'd2: new_bits = {old_bits[2], 2'b01};
			default: new_bits = {old_bits[2], 2'b00};
		endcase
	end

endmodule

/* src/tag_array.sv */
/* Tags and valid bits of all four ways. Reads have one cycle of latency;
   a write goes to the set presented in the previous cycle. */
module tag_array
	import cache_tag_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic [SET_INDEX_WIDTH-1:0] set_i,
	input  logic                       wr_en_i,
	input  way_t                       wr_way_i,
	input  logic [TAG_WIDTH-1:0]       wr_tag_i,
	output tag_set_t                   set_o
);

	logic [SET_INDEX_WIDTH-1:0]        set_q;
	logic [NUM_WAYS-1:0]               valid_q [NUM_SETS];
	logic [NUM_WAYS-1:0]               valid_rd_q;
	logic [NUM_WAYS-1:0]               wr_onehot;
	logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rd;

	// Writes land in the set that was read in the previous cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			set_q <= '0;
		else
			set_q <= set_i;
	end

	assign wr_onehot = NUM_WAYS'(1) << wr_way_i;

	// One tag memory per way, only the selected way is written
	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : g_way
		sram_1r1w #(
			.DATA_WIDTH(TAG_WIDTH),
			.SIZE(NUM_SETS)
		) tag_mem_inst (
			.clk(clk),
			.reset(reset),
			.rd_addr_i(set_i),
			.rd_data_o(tag_rd[w]),
			.wr_en_i(wr_en_i && wr_way_i == way_t'(w)),
			.wr_addr_i(set_q),
			.wr_data_i(wr_tag_i)
		);
	end

	// Valid bits live in flops so that reset empties the whole cache
	// Once set a valid bit stays set, there is no invalidation
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				valid_q[s] <= '0;
			valid_rd_q <= '0;
		end
		else
		begin
			if (wr_en_i)
				valid_q[set_q] <= valid_q[set_q] | wr_onehot;
			// Same latency and forwarding as the tag memories
			if (wr_en_i && set_q == set_i)
				valid_rd_q <= valid_q[set_i] | wr_onehot;
			else
				valid_rd_q <= valid_q[set_i];
		end
	end

	assign set_o.valid = valid_rd_q;
	assign set_o.tag = tag_rd;

endmodule

/* src/lookup_stage.sv */
/* Resolves one lookup per cycle against the set read in the previous cycle.
   No back-pressure; a strobe always produces a response one cycle later. */
module lookup_stage
	import cache_tag_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req_valid_i,
	input  lookup_req_t          req_i,
	input  tag_set_t             set_i,
	input  way_t                 lru_way_i,
	output logic                 resp_valid_o,
	output lookup_resp_t         resp_o,
	output logic                 tag_wr_en_o,
	output way_t                 tag_wr_way_o,
	output logic [TAG_WIDTH-1:0] tag_wr_tag_o,
	output logic                 mru_update_o,
	output way_t                 mru_way_o
);

	logic                 valid_q;
	lookup_req_t          req_q;
	logic [TAG_WIDTH-1:0] lookup_tag;
	logic                 hit;
	way_t                 hit_way;
	logic                 has_free;
	way_t                 free_way;
	way_t                 chosen_way;

	// The request strobe delayed by one cycle becomes the response strobe
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= req_valid_i;
	end

	// Address of the request that is resolved in the next cycle
	always_ff @(posedge clk)
	begin
		if (req_valid_i)
			req_q <= req_i;
	end

	assign lookup_tag = req_tag(req_q);

	// Tag compare, and in the same pass the lowest numbered empty way
	// Scanning from the top down leaves the lowest match in place
	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		has_free = 1'b0;
		free_way = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (set_i.valid[w] && set_i.tag[w] == lookup_tag)
			begin
				hit = 1'b1;
				hit_way = way_t'(w);
			end
			if (!set_i.valid[w])
			begin
				has_free = 1'b1;
				free_way = way_t'(w);
			end
		end
	end

	// Priority is hit, then an empty way, then the pseudo-LRU victim
	always_comb
	begin
		resp_o.victim_tag = '0;
		if (hit)
		begin
			resp_o.result = RESULT_HIT;
			chosen_way = hit_way;
		end
		else if (has_free)
		begin
			resp_o.result = RESULT_FILL;
			chosen_way = free_way;
		end
		else
		begin
			resp_o.result = RESULT_EVICT;
			chosen_way = lru_way_i;
			resp_o.victim_tag = set_i.tag[lru_way_i];
		end
		resp_o.way = chosen_way;
	end

	assign resp_valid_o = valid_q;

	// A miss installs the new tag in the chosen way
	assign tag_wr_en_o = valid_q && !hit;
	assign tag_wr_way_o = chosen_way;
	assign tag_wr_tag_o = lookup_tag;

	// Every lookup makes the way it used the most recently used one
	assign mru_update_o = valid_q;
	assign mru_way_o = chosen_way;

endmodule

/* src/cache_tag_top.sv */
/* Tag side of a 4-way cache, no data storage. One lookup per cycle, the
   response follows the request strobe by exactly one clock. */
module cache_tag_top
	import cache_tag_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         req_valid_i,
	input  lookup_req_t  req_i,
	output logic         resp_valid_o,
	output lookup_resp_t resp_o
);

	tag_set_t             tag_set;
	way_t                 lru_way;
	logic                 tag_wr_en;
	way_t                 tag_wr_way;
	logic [TAG_WIDTH-1:0] tag_wr_tag;
	logic                 mru_update;
	way_t                 mru_way;

	// Both memories are read straight from the incoming set index
	tag_array tag_array_inst (
		.clk(clk),
		.reset(reset),
		.set_i(req_set(req_i)),
		.wr_en_i(tag_wr_en),
		.wr_way_i(tag_wr_way),
		.wr_tag_i(tag_wr_tag),
		.set_o(tag_set)
	);

	cache_lru cache_lru_inst (
		.clk(clk),
		.reset(reset),
		.set_i(req_set(req_i)),
		.update_mru_i(mru_update),
		.new_mru_way_i(mru_way),
		.lru_way_o(lru_way)
	);

	// The writes go back to the set each memory latched on its own
	lookup_stage lookup_stage_inst (
		.clk(clk),
		.reset(reset),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.set_i(tag_set),
		.lru_way_i(lru_way),
		.resp_valid_o(resp_valid_o),
		.resp_o(resp_o),
		.tag_wr_en_o(tag_wr_en),
		.tag_wr_way_o(tag_wr_way),
		.tag_wr_tag_o(tag_wr_tag),
		.mru_update_o(mru_update),
		.mru_way_o(mru_way)
	);

endmodule

/* bench/cache_tag_props.sv */
/* Checks on the lookup stage, bound into every lookup_stage instance.
   All checks are held off while reset is high. */
module cache_tag_props
	import cache_tag_pkg::*;
(
	input logic         clk,
	input logic         reset,
	input logic         req_valid_i,
	input logic         resp_valid_i,
	input lookup_resp_t resp_i,
	input logic         tag_wr_en_i,
	input logic         mru_update_i,
	input way_t         mru_way_i
);

	timeunit 1ns;
	timeprecision 1ns;

	// Number of failed assertions so far, read by the testbench after every step
	int assert_fail_count;

	initial
		assert_fail_count = 0;

	// Each strobe is answered exactly one clock later, and only then
	resp_follows_req: assert property (@(posedge clk) disable iff (reset)
		resp_valid_i == $past(req_valid_i))
	else
	begin
		assert_fail_count++;
		$error("response strobe does not follow the request strobe by one cycle");
	end

	// A hit leaves the tag memories alone
	no_write_on_hit: assert property (@(posedge clk) disable iff (reset)
		(resp_valid_i && resp_i.result == RESULT_HIT) |-> !tag_wr_en_i)
	else
	begin
		assert_fail_count++;
		$error("tag write issued on a hit");
	end

	// The way reported is the way that becomes most recently used
	mru_with_resp: assert property (@(posedge clk) disable iff (reset)
		resp_valid_i |-> (mru_update_i && mru_way_i == resp_i.way))
	else
	begin
		assert_fail_count++;
		$error("response without a matching MRU update");
	end

endmodule

bind lookup_stage cache_tag_props props_inst (
	.clk(clk),
	.reset(reset),
	.req_valid_i(req_valid_i),
	.resp_valid_i(resp_valid_o),
	.resp_i(resp_o),
	.tag_wr_en_i(tag_wr_en_o),
	.mru_update_i(mru_update_o),
	.mru_way_i(mru_way_o)
);

/* bench/cache_tag_tb.sv */
/* Testbench for the cache tag top. A behavioral model predicts every response;
   the run stops at the first mismatch. Random part uses sets 0 to 3 only. */
module cache_tag_tb
	import cache_tag_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 100;
	localparam int TABLE_LEN = 24;
	localparam int RANDOM_COUNT = 200;
	// Two cycles per step leaves room for reset and the drain steps
	localparam int WATCHDOG_CYCLES = 2 * (TABLE_LEN + RANDOM_COUNT) + 20;

	typedef struct packed {
		logic        valid;
		lookup_req_t req;
	} stim_t;

	logic         clk;
	logic         reset;
	logic         req_valid;
	lookup_req_t  lookup_req;
	logic         resp_valid;
	lookup_resp_t lookup_resp;

	// Model state per set and way
	logic [TAG_WIDTH-1:0] model_tag [NUM_SETS][NUM_WAYS];
	logic                 model_valid [NUM_SETS][NUM_WAYS];
	// Tree per set, the root picks a pair and one bit picks inside each pair
	logic                 tree_root [NUM_SETS];
	logic                 tree_left [NUM_SETS];
	logic                 tree_right [NUM_SETS];
	// Request strobed in the previous step, answered in this one
	logic                 pend_valid;
	lookup_req_t          pend_req;
	integer               seed;

	// Address is the tag followed by the set index nibble
	stim_t stim_table [TABLE_LEN] = '{
		// Four tags fill set 3 in consecutive cycles
		{1'b1, 12'h113}, {1'b1, 12'h223}, {1'b1, 12'h333}, {1'b1, 12'h443},
		{1'b0, 12'h000},
		// Every one of them hits where it was installed
		{1'b1, 12'h223}, {1'b1, 12'h113}, {1'b1, 12'h443}, {1'b1, 12'h333},
		// A fifth tag evicts, then the evicted tag misses
		{1'b1, 12'h553}, {1'b1, 12'h223},
		{1'b0, 12'h000},
		// Fill then hit on the very next cycle
		{1'b1, 12'h667}, {1'b1, 12'h667},
		// Other sets interleaved with set 3
		{1'b1, 12'h115}, {1'b1, 12'h553}, {1'b1, 12'h115}, {1'b1, 12'h667},
		{1'b1, 12'h113}, {1'b1, 12'h333},
		// Set 5 fills up and then evicts
		{1'b1, 12'h225}, {1'b1, 12'h335}, {1'b1, 12'h445}, {1'b1, 12'h555}
	};

	cache_tag_top cache_tag_top_inst (
		.clk(clk),
		.reset(reset),
		.req_valid_i(req_valid),
		.req_i(lookup_req),
		.resp_valid_o(resp_valid),
		.resp_o(lookup_resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic clear_model();
		for (int s = 0; s < NUM_SETS; s++)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				model_tag[s][w] = '0;
				model_valid[s][w] = 1'b0;
			end
			tree_root[s] = 1'b0;
			tree_left[s] = 1'b0;
			tree_right[s] = 1'b0;
		end
	endtask

	// Least recently used way as the tree bits point to it
	function automatic int lru_way(int s);
		if (!tree_root[s])
			return tree_left[s] ? 1 : 0;
		else
			return tree_right[s] ? 3 : 2;
	endfunction

	// The root points to the other pair and the pair bit to the sibling way
	function automatic void make_mru(int s, int way);
		if (way < 2)
		begin
			tree_root[s] = 1'b1;
			tree_left[s] = (way == 0);
		end
		else
		begin
			tree_root[s] = 1'b0;
			tree_right[s] = (way == 2);
		end
	endfunction

	// Expected response for one lookup, the model state moves on with it
	task automatic predict(input lookup_req_t req, output lookup_resp_t expected);
		int                   s;
		int                   way;
		logic [TAG_WIDTH-1:0] tag;
		bit                   done;
		s = int'(req.addr[SET_INDEX_WIDTH-1:0]);
		tag = req.addr[ADDR_WIDTH-1:SET_INDEX_WIDTH];
		way = 0;
		done = 1'b0;
		expected = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (!done && model_valid[s][w] && model_tag[s][w] == tag)
			begin
				done = 1'b1;
				way = w;
				expected.result = RESULT_HIT;
			end
		end
		// Lowest empty way gets the fill
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (!done && !model_valid[s][w])
			begin
				done = 1'b1;
				way = w;
				expected.result = RESULT_FILL;
			end
		end
		if (!done)
		begin
			way = lru_way(s);
			expected.result = RESULT_EVICT;
			expected.victim_tag = model_tag[s][way];
		end
		if (expected.result != RESULT_HIT)
		begin
			model_tag[s][way] = tag;
			model_valid[s][way] = 1'b1;
		end
		make_mru(s, way);
		expected.way = way_t'(way);
	endtask

	task automatic check_valid(input logic got, input logic expected);
		if (got !== expected)
		begin
			$display("ERR %0t: response strobe is %b, expected %b", $time, got, expected);
			$display("Test failures found");
			$fatal(1, "response strobe mismatch");
		end
	endtask

	task automatic check_resp(input lookup_resp_t got, input lookup_resp_t expected,
		input lookup_req_t req);
		if (got !== expected)
		begin
			$display("ERR %0t: addr %h got %s/%0d/%h, expected %s/%0d/%h", $time,
				req.addr, got.result.name(), got.way, got.victim_tag,
				expected.result.name(), expected.way, expected.victim_tag);
			$display("Test failures found");
			$fatal(1, "response mismatch");
		end
	endtask

	// Any failed assertion on the lookup stage ends the run at once
	task automatic check_assertions();
		if (cache_tag_top_inst.lookup_stage_inst.props_inst.assert_fail_count != 0)
		begin
			$display("An assertion on the lookup stage failed at time %0t", $time);
			$display("Test failures found");
			$fatal(1, "assertion failures");
		end
	endtask

	// On the falling edge the outputs are settled, so check first and then drive
	task automatic apply(input logic valid, input lookup_req_t req);
		lookup_resp_t expected;
		@(negedge clk);
		check_assertions();
		check_valid(resp_valid, pend_valid);
		if (pend_valid)
		begin
			predict(pend_req, expected);
			check_resp(lookup_resp, expected, pend_req);
		end
		req_valid = valid;
		lookup_req = req;
		pend_valid = valid;
		pend_req = req;
	endtask

	initial
	begin
		lookup_req_t rand_req;
		logic [31:0] rnd;
		clk = 1'b0;
		seed = 32'h5ea2;
		reset = 1'b1;
		req_valid = 1'b0;
		lookup_req = '0;
		pend_valid = 1'b0;
		pend_req = '0;
		clear_model();
		repeat (4) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++)
			apply(stim_table[i].valid, stim_table[i].req);
		// Eight tags over four sets mix hits, fills and evictions
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			rnd = $random(seed);
			rand_req.addr = {8'h10 + {5'b0, rnd[2:0]}, 2'b00, rnd[4:3]};
			apply(rnd[7:5] != 3'b000, rand_req);
		end
		// Two idle steps collect the last response
		apply(1'b0, '0);
		apply(1'b0, '0);
		$display("All tests passed!");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish in the expected time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule

/* list.f */
src/cache_tag_pkg.sv
src/sram_1r1w.sv
src/cache_lru.sv
src/tag_array.sv
src/lookup_stage.sv
src/cache_tag_top.sv
bench/cache_tag_props.sv
bench/cache_tag_tb.sv

/* Makefile */
# Verilator build and run of the cache tag testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fails unless the run passes"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f list.f --top-module cache_tag_tb -o cache_tag_sim
	./obj_dir/cache_tag_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
